// File: cache/dcache_access_decode.sv
`timescale 1ns/1ns

module dcache_access_decode (
    input  mem_access_pkg::cpu_req_t     cpu_req,
    output mem_access_pkg::decoded_req_t dec
);

    logic [1:0] byte_off;
    logic [3:0] size_mask;

    assign byte_off = cpu_req.addr.fields.byte_off;

    always_comb begin
        dec       = '0;
        size_mask = 4'b0000;

        dec.valid    = cpu_req.valid;
        dec.addr     = cpu_req.addr;
        dec.is_store = cpu_req.we;

        if (cpu_req.we) begin
            case (cpu_req.funct3)
                mem_access_pkg::SB: dec.size = mem_access_pkg::SIZE_BYTE;
                mem_access_pkg::SH: dec.size = mem_access_pkg::SIZE_HALF;
                mem_access_pkg::SW: dec.size = mem_access_pkg::SIZE_WORD;
                default:            dec.illegal = 1'b1;
            endcase
        end else begin
            case (cpu_req.funct3)
                mem_access_pkg::LB: begin
                    dec.size = mem_access_pkg::SIZE_BYTE;
                    dec.sign = 1'b1;
                end
                mem_access_pkg::LH: begin
                    dec.size = mem_access_pkg::SIZE_HALF;
                    dec.sign = 1'b1;
                end
                mem_access_pkg::LW:  dec.size = mem_access_pkg::SIZE_WORD;
                mem_access_pkg::LBU: dec.size = mem_access_pkg::SIZE_BYTE;
                mem_access_pkg::LHU: dec.size = mem_access_pkg::SIZE_HALF;
                default:             dec.illegal = 1'b1;
            endcase
        end

        // Byte enables only for a legal store, aligned access assumed
        if (cpu_req.we && !dec.illegal) begin
            case (dec.size)
                mem_access_pkg::SIZE_BYTE: size_mask = 4'b0001;
                mem_access_pkg::SIZE_HALF: size_mask = 4'b0011;
                default:                   size_mask = 4'b1111;
            endcase
            dec.byte_mask  = size_mask << byte_off;
            dec.store_data = cpu_req.wdata << {byte_off, 3'b000};  // Move into lanes
        end
    end

endmodule

// File: cache/dcache_controller.sv
`timescale 1ns/1ns

module dcache_controller (
    input  logic                         clk,
    input  logic                         reset,
    input  mem_access_pkg::decoded_req_t dec,
    output logic                         cpu_ready,
    output mem_access_pkg::ctrl_result_t result,
    output mem_access_pkg::mem_req_t     mem_req,
    input  mem_access_pkg::mem_resp_t    mem_resp
);

    localparam int SETS     = cache_geom_pkg::SET_COUNT;
    localparam int WAYS     = cache_geom_pkg::WAY_COUNT;
    localparam int TAG_W    = cache_geom_pkg::TAG_BITS;
    localparam int SET_W    = cache_geom_pkg::SET_BITS;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL,
        ST_RESPOND
    } state_e;

    state_e state;

    cache_geom_pkg::cache_line_t data_q [SETS][WAYS];
    logic [TAG_W-1:0]            tag_q [SETS][WAYS];
    logic [WAYS-1:0]             valid_q [SETS];
    logic [WAYS-1:0]             dirty_q [SETS];
    logic [SETS-1:0]             lru_q;      // Way to evict next, per set

    mem_access_pkg::decoded_req_t req_q;     // Request waiting on a miss
    logic                         victim_q;

    logic [SET_W-1:0]            set_idx;
    logic [SET_W-1:0]            req_set;
    logic [WAYS-1:0]             way_hit;
    logic                        hit;
    logic                        hit_way;
    logic                        victim;
    logic                        victim_dirty;
    logic                        accept;
    cache_geom_pkg::cache_line_t hit_line;
    cache_geom_pkg::cache_line_t hit_merged;
    cache_geom_pkg::cache_line_t refill_merged;
    cache_geom_pkg::cache_addr_u victim_addr;

    // Overwrite the masked bytes of the addressed word
    function automatic cache_geom_pkg::cache_line_t merge_store(
        input cache_geom_pkg::cache_line_t  line,
        input mem_access_pkg::decoded_req_t req
    );
        cache_geom_pkg::cache_line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (req.byte_mask[b]) begin
                merged[req.addr.fields.word_off][8*b +: 8] = req.store_data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    function automatic cache_geom_pkg::cache_addr_u line_addr(
        input cache_geom_pkg::cache_addr_u addr
    );
        cache_geom_pkg::cache_addr_u line;
        line                 = addr;
        line.fields.word_off = '0;
        line.fields.byte_off = '0;
        return line;
    endfunction

    assign set_idx = dec.addr.fields.set_idx;
    assign req_set = req_q.addr.fields.set_idx;

    // Both ways compared in the same cycle
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_hit[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == dec.addr.fields.tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];
    assign victim       = lru_q[set_idx];
    assign victim_dirty = valid_q[set_idx][victim] && dirty_q[set_idx][victim];

    assign hit_line      = data_q[set_idx][hit_way];
    assign hit_merged    = merge_store(hit_line, dec);
    assign refill_merged = merge_store(mem_resp.rdata, req_q);  // Loads carry no mask

    always_comb begin
        victim_addr                 = '0;
        victim_addr.fields.tag      = tag_q[set_idx][victim];
        victim_addr.fields.set_idx  = set_idx;
    end

    assign cpu_ready = (state == ST_IDLE);
    assign accept    = dec.valid && cpu_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_IDLE;
            result.valid  <= 1'b0;
            mem_req.read  <= 1'b0;
            mem_req.write <= 1'b0;
            lru_q         <= '0;
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            result.valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        result.byte_off <= dec.addr.fields.byte_off;
                        result.size     <= dec.size;
                        result.sign     <= dec.sign;
                        result.raw_word <= '0;

                        if (dec.illegal) begin
                            result.valid <= 1'b1;
                            result.hit   <= 1'b0;
                            result.err   <= 1'b1;
                        end else if (hit) begin
                            result.valid <= 1'b1;
                            result.hit   <= 1'b1;
                            result.err   <= 1'b0;
                            lru_q[set_idx] <= ~hit_way;
                            if (dec.is_store) begin
                                data_q[set_idx][hit_way]  <= hit_merged;
                                dirty_q[set_idx][hit_way] <= 1'b1;
                            end else begin
                                result.raw_word <= hit_line[dec.addr.fields.word_off];
                            end
                        end else begin
                            req_q    <= dec;
                            victim_q <= victim;
                            if (victim_dirty) begin
                                mem_req.write <= 1'b1;
                                mem_req.addr  <= victim_addr;
                                mem_req.wdata <= data_q[set_idx][victim];
                                state         <= ST_WRITEBACK;
                            end else begin
                                mem_req.read <= 1'b1;
                                mem_req.addr <= line_addr(dec.addr);
                                state        <= ST_REFILL;
                            end
                        end
                    end
                end

                ST_WRITEBACK: begin
                    if (mem_resp.ready) begin
                        mem_req.write <= 1'b0;
                        mem_req.read  <= 1'b1;
                        mem_req.addr  <= line_addr(req_q.addr);
                        state         <= ST_REFILL;
                    end
                end

                ST_REFILL: begin
                    if (mem_resp.ready) begin
                        mem_req.read <= 1'b0;
                        data_q[req_set][victim_q]  <= refill_merged;
                        tag_q[req_set][victim_q]   <= req_q.addr.fields.tag;
                        valid_q[req_set][victim_q] <= 1'b1;
                        dirty_q[req_set][victim_q] <= req_q.is_store;
                        lru_q[req_set]             <= ~victim_q;

                        result.valid    <= 1'b1;
                        result.hit      <= 1'b0;
                        result.err      <= 1'b0;
                        result.raw_word <= req_q.is_store ? 32'd0 :
                                           mem_resp.rdata[req_q.addr.fields.word_off];
                        state           <= ST_RESPOND;
                    end
                end

                ST_RESPOND: state <= ST_IDLE;  // Hold off the next request one cycle

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: cache/dcache_load_align.sv
`timescale 1ns/1ns

module dcache_load_align (
    input  mem_access_pkg::ctrl_result_t result,
    output mem_access_pkg::cpu_resp_t    cpu_resp
);

    logic [31:0] shifted;  // Addressed byte moved down to bit 0
    logic        ext;

    assign shifted = result.raw_word >> {result.byte_off, 3'b000};

    always_comb begin
        cpu_resp.valid = result.valid;
        cpu_resp.hit   = result.hit;
        cpu_resp.err   = result.err;

        // Stores and errors arrive with a zero word
        case (result.size)
            mem_access_pkg::SIZE_BYTE: begin
                ext            = result.sign & shifted[7];
                cpu_resp.rdata = {{24{ext}}, shifted[7:0]};
            end
            mem_access_pkg::SIZE_HALF: begin
                ext            = result.sign & shifted[15];
                cpu_resp.rdata = {{16{ext}}, shifted[15:0]};
            end
            default: begin
                ext            = 1'b0;
                cpu_resp.rdata = result.raw_word;
            end
        endcase
    end

endmodule

// File: common/cache_geom_pkg.sv
package cache_geom_pkg;

    // Line and word geometry
    localparam int LINE_BITS      = 128;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_BITS      = LINE_BITS / WORDS_PER_LINE;

    // Two ways of sixteen sets
    localparam int SET_COUNT = 16;
    localparam int WAY_COUNT = 2;

    localparam int TAG_BITS      = 24;
    localparam int SET_BITS      = $clog2(SET_COUNT);
    localparam int WORD_OFF_BITS = $clog2(WORDS_PER_LINE);
    localparam int BYTE_OFF_BITS = 2;

    // Word 0 sits in the low bits of the line
    typedef logic [WORDS_PER_LINE-1:0][WORD_BITS-1:0] cache_line_t;

    /*
     31                      8 7    4 3  2 1  0
     +------------------------+------+----+----+
     |          TAG           | SET  | WO | BO |
     +------------------------+------+----+----+
    */
    typedef struct packed {
        logic [TAG_BITS-1:0]      tag;
        logic [SET_BITS-1:0]      set_idx;
        logic [WORD_OFF_BITS-1:0] word_off;
        logic [BYTE_OFF_BITS-1:0] byte_off;
    } addr_fields_t;

    // Same 32 bits seen as a bus address or as cache fields
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t fields;
    } cache_addr_u;

endpackage

// File: common/mem_access_pkg.sv
package mem_access_pkg;

    // Load funct3 codes (we low)
    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;

    // Store funct3 codes (we high)
    localparam logic [2:0] SB = 3'b000;
    localparam logic [2:0] SH = 3'b001;
    localparam logic [2:0] SW = 3'b010;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef struct packed {
        logic                        valid;
        logic                        we;
        logic [2:0]                  funct3;
        cache_geom_pkg::cache_addr_u addr;
        logic [31:0]                 wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                        valid;
        logic                        is_store;
        logic                        illegal;     // Unknown funct3 for this direction
        access_size_e                size;
        logic                        sign;
        cache_geom_pkg::cache_addr_u addr;
        logic [3:0]                  byte_mask;   // Zero for loads
        logic [31:0]                 store_data;  // Already in its byte lanes
    } decoded_req_t;

    typedef struct packed {
        logic         valid;
        logic         hit;
        logic         err;
        logic [31:0]  raw_word;
        logic [1:0]   byte_off;
        access_size_e size;
        logic         sign;
    } ctrl_result_t;

    typedef struct packed {
        logic        valid;
        logic        hit;
        logic        err;
        logic [31:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic                        read;
        logic                        write;
        cache_geom_pkg::cache_addr_u addr;   // Offsets always zero
        cache_geom_pkg::cache_line_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic                        ready;
        cache_geom_pkg::cache_line_t rdata;
    } mem_resp_t;

endpackage

// File: dcache.f
common/cache_geom_pkg.sv
common/mem_access_pkg.sv
cache/dcache_access_decode.sv
cache/dcache_controller.sv
cache/dcache_load_align.sv
logic/dcache_top.sv
verif/dcache_clk_gen.sv
verif/dcache_tb.sv

// File: logic/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                      clk,
    input  logic                      reset,

    // Processor side
    input  mem_access_pkg::cpu_req_t  cpu_req,
    output logic                      cpu_ready,
    output mem_access_pkg::cpu_resp_t cpu_resp,

    // Backing memory side
    output mem_access_pkg::mem_req_t  mem_req,
    input  mem_access_pkg::mem_resp_t mem_resp
);

    mem_access_pkg::decoded_req_t dec;
    mem_access_pkg::ctrl_result_t result;

    // funct3 to size, sign, byte mask
    dcache_access_decode u_access_decode (
        .cpu_req (cpu_req),
        .dec     (dec)
    );

    // Lookup, writeback and refill
    dcache_controller u_controller (
        .clk       (clk),
        .reset     (reset),
        .dec       (dec),
        .cpu_ready (cpu_ready),
        .result    (result),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    // Registered result to extended load data
    dcache_load_align u_load_align (
        .result   (result),
        .cpu_resp (cpu_resp)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f dcache.f --top-module dcache_tb > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vdcache_tb > sim.log 2>&1 || true
grep -q "Errors found" sim.log && { echo "Simulation failed, see sim.log"; exit 1; } \
    || echo "Simulation passed"

// File: verif/dcache_clk_gen.sv
`timescale 1ns/1ns

module dcache_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;  // Half period per phase
        end
    end

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

    localparam int NUM_REQS    = 600;
    localparam int CYCLE_LIMIT = NUM_REQS * 12 + 20;  // Worst case miss plus reset

    logic                      clk;
    logic                      reset;
    mem_access_pkg::cpu_req_t  cpu_req;
    logic                      cpu_ready;
    mem_access_pkg::cpu_resp_t cpu_resp;
    mem_access_pkg::mem_req_t  mem_req;
    mem_access_pkg::mem_resp_t mem_resp;

    integer      seed = 84226;
    logic [31:0] fill_key;

    // Backing memory by line address, golden data by word address
    cache_geom_pkg::cache_line_t backing_mem [logic [31:0]];
    logic [31:0]                 golden_mem [logic [31:0]];

    // Shadow copy of the tag state
    logic [cache_geom_pkg::TAG_BITS-1:0] sh_tag [cache_geom_pkg::SET_COUNT][2];
    logic [1:0]                          sh_valid [cache_geom_pkg::SET_COUNT];
    logic [1:0]                          sh_dirty [cache_geom_pkg::SET_COUNT];
    logic                                sh_lru [cache_geom_pkg::SET_COUNT];

    mem_access_pkg::mem_req_t exp_mem_q [$];   // Predicted transfers, in order
    int                       delay_q [$];     // Ready delay of each transfer
    int                       xfer_done = 0;

    // Eight legal codes, then one illegal load and one illegal store
    logic       kind_we [10] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    logic [2:0] kind_f3 [10] = '{
        mem_access_pkg::LB, mem_access_pkg::LH, mem_access_pkg::LW,
        mem_access_pkg::LBU, mem_access_pkg::LHU,
        mem_access_pkg::SB, mem_access_pkg::SH, mem_access_pkg::SW,
        3'b011, 3'b100
    };

    dcache_clk_gen #(.PERIOD(40)) u_clk_gen (.clk(clk));

    dcache_top u_dcache_top (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_ready (cpu_ready),
        .cpu_resp  (cpu_resp),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp)
    );

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        abort_run();
    endtask

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ fill_key;
    endfunction

    function automatic logic [31:0] golden_word(input logic [31:0] addr);
        if (golden_mem.exists(addr)) return golden_mem[addr];
        return fill_word(addr);  // Never stored yet
    endfunction

    function automatic cache_geom_pkg::cache_line_t golden_line(input logic [31:0] line_addr);
        cache_geom_pkg::cache_line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w] = golden_word(line_addr + 32'(4 * w));
        end
        return line;
    endfunction

    function automatic cache_geom_pkg::cache_line_t backing_line(input logic [31:0] line_addr);
        cache_geom_pkg::cache_line_t line;
        if (backing_mem.exists(line_addr)) return backing_mem[line_addr];
        for (int w = 0; w < 4; w++) begin
            line[w] = fill_word(line_addr + 32'(4 * w));
        end
        return line;
    endfunction

    // Load value from golden bytes, extended per funct3
    function automatic logic [31:0] expected_load(input mem_access_pkg::cpu_req_t req);
        logic [31:0] word;
        word = golden_word({req.addr.raw[31:2], 2'b00}) >> {req.addr.fields.byte_off, 3'b000};
        case (req.funct3)
            mem_access_pkg::LB:  return {{24{word[7]}}, word[7:0]};
            mem_access_pkg::LH:  return {{16{word[15]}}, word[15:0]};
            mem_access_pkg::LBU: return {24'd0, word[7:0]};
            mem_access_pkg::LHU: return {16'd0, word[15:0]};
            default:             return word;
        endcase
    endfunction

    task automatic apply_store(input mem_access_pkg::cpu_req_t req);
        logic [31:0] word_addr;
        logic [31:0] word;
        int          nbytes;
        word_addr = {req.addr.raw[31:2], 2'b00};
        word      = golden_word(word_addr);
        nbytes    = (req.funct3 == mem_access_pkg::SB) ? 1 :
                    (req.funct3 == mem_access_pkg::SH) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            word[8 * (int'(req.addr.fields.byte_off) + b) +: 8] = req.wdata[8 * b +: 8];
        end
        golden_mem[word_addr] = word;
    endtask

    task automatic queue_transfer(input mem_access_pkg::mem_req_t xfer);
        logic [31:0] r;
        r = $random(seed);
        exp_mem_q.push_back(xfer);
        delay_q.push_back(int'(r[1:0]));  // 0 to 3 cycles before ready
    endtask

    task automatic check_resp(input mem_access_pkg::cpu_resp_t got,
                              input mem_access_pkg::cpu_resp_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf(
                "cpu_resp valid=%0b hit=%0b err=%0b rdata=%h, expected %0b %0b %0b %h",
                got.valid, got.hit, got.err, got.rdata, exp.valid, exp.hit, exp.err, exp.rdata));
        end
    endtask

    task automatic check_mem_write(input mem_access_pkg::mem_req_t got,
                                   input mem_access_pkg::mem_req_t exp);
        if (got.write !== exp.write || got.read !== exp.read ||
            got.addr.raw !== exp.addr.raw || got.wdata !== exp.wdata) begin
            report_mismatch($sformatf("writeback addr=%h data=%h, expected write=%0b addr=%h data=%h",
                got.addr.raw, got.wdata, exp.write, exp.addr.raw, exp.wdata));
        end
    endtask

    task automatic check_mem_read(input mem_access_pkg::mem_req_t got,
                                  input mem_access_pkg::mem_req_t exp);
        if (got.read !== exp.read || got.write !== exp.write || got.addr.raw !== exp.addr.raw) begin
            report_mismatch($sformatf("line read addr=%h, expected read=%0b addr=%h",
                got.addr.raw, exp.read, exp.addr.raw));
        end
    endtask

    task automatic run_request();
        mem_access_pkg::cpu_req_t  req;
        mem_access_pkg::cpu_resp_t exp;
        mem_access_pkg::mem_req_t  xfer;
        logic [31:0]               r;
        logic [3:0]                set_idx;
        int                        kind;
        int                        tag_sel;
        logic                      way;
        logic                      hit;

        r       = $random(seed);
        kind    = int'(r[7:0]) % 10;
        tag_sel = int'(r[15:8]) % 6;
        req                      = '0;
        req.valid                = 1'b1;
        req.we                   = kind_we[kind];
        req.funct3               = kind_f3[kind];
        req.wdata                = $random(seed);
        req.addr.fields.tag      = 24'h001000 + 24'(tag_sel * 855);
        req.addr.fields.set_idx  = {r[17:16], 2'b10};  // Four of the sixteen sets
        req.addr.fields.word_off = r[19:18];
        case (req.funct3[1:0])  // Aligned to the access size
            2'b00:   req.addr.fields.byte_off = r[21:20];
            2'b01:   req.addr.fields.byte_off = {r[20], 1'b0};
            default: req.addr.fields.byte_off = 2'b00;
        endcase
        set_idx = req.addr.fields.set_idx;

        hit = 1'b0;
        way = sh_lru[set_idx];
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[set_idx][w] && sh_tag[set_idx][w] == req.addr.fields.tag) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end

        exp       = '0;
        exp.valid = 1'b1;
        if (kind >= 8) begin
            exp.err = 1'b1;  // Shadow and golden untouched
        end else begin
            exp.hit = hit;
            if (!hit) begin
                if (sh_valid[set_idx][way] && sh_dirty[set_idx][way]) begin
                    xfer                     = '0;
                    xfer.write               = 1'b1;
                    xfer.addr.fields.tag     = sh_tag[set_idx][way];
                    xfer.addr.fields.set_idx = set_idx;
                    xfer.wdata               = golden_line(xfer.addr.raw);
                    queue_transfer(xfer);
                end
                xfer          = '0;
                xfer.read     = 1'b1;
                xfer.addr.raw = {req.addr.raw[31:4], 4'h0};
                queue_transfer(xfer);
                sh_tag[set_idx][way]   = req.addr.fields.tag;
                sh_valid[set_idx][way] = 1'b1;
                sh_dirty[set_idx][way] = 1'b0;
            end
            sh_lru[set_idx] = ~way;
            if (req.we) begin
                apply_store(req);
                sh_dirty[set_idx][way] = 1'b1;
            end else begin
                exp.rdata = expected_load(req);
            end
        end

        if (r[31:29] == 3'b000) begin  // Occasional idle cycle
            @(posedge clk);
            #1;
        end
        cpu_req = req;
        while (!cpu_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);  // Accept edge
        #1;
        cpu_req.valid = 1'b0;

        if (kind >= 8 || hit) begin
            check_resp(cpu_resp, exp);
            if (!cpu_ready) report_problem("cpu_ready fell after a hit or illegal request");
        end else begin
            while (!cpu_resp.valid) begin
                @(posedge clk);
                #1;
            end
            check_resp(cpu_resp, exp);
            if (cpu_ready) report_problem("cpu_ready was high in the miss response cycle");
            if (xfer_done != exp_mem_q.size()) begin
                report_problem("A predicted memory transfer never took place");
            end
        end
    endtask

    // Backing memory with random ready delay
    initial begin : memory_model
        mem_access_pkg::mem_req_t active;
        logic                     busy;
        int                       delay;
        mem_resp = '0;
        active   = '0;
        busy     = 1'b0;
        delay    = 0;
        forever begin
            @(posedge clk);
            #1;
            mem_resp.ready = 1'b0;
            if (mem_req.read && mem_req.write) begin
                report_problem("Memory read and write strobes were high together");
            end
            if (busy && (mem_req.read !== active.read || mem_req.write !== active.write ||
                         mem_req.addr.raw !== active.addr.raw ||
                         (active.write && mem_req.wdata !== active.wdata))) begin
                report_problem("Memory request changed before ready was given");
            end
            if (!busy && (mem_req.read || mem_req.write)) begin
                if (xfer_done >= exp_mem_q.size()) begin
                    report_problem("Memory transfer started without a predicted miss");
                end
                if (mem_req.write) check_mem_write(mem_req, exp_mem_q[xfer_done]);
                else check_mem_read(mem_req, exp_mem_q[xfer_done]);
                delay  = delay_q[xfer_done];
                active = mem_req;
                busy   = 1'b1;
            end
            if (busy && delay == 0) begin
                mem_resp.ready = 1'b1;
                if (active.read) mem_resp.rdata = backing_line(active.addr.raw);
                else backing_mem[active.addr.raw] = active.wdata;
                busy      = 1'b0;
                xfer_done = xfer_done + 1;
            end else if (busy) begin
                delay = delay - 1;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                report_problem($sformatf("Timeout, test not finished after %0d cycles", cycles));
            end
        end
    end

    initial begin : stimulus
        cpu_req  = '0;
        reset    = 1'b1;
        fill_key = $random(seed);
        for (int s = 0; s < cache_geom_pkg::SET_COUNT; s++) begin
            sh_valid[s] = 2'b00;
            sh_dirty[s] = 2'b00;
            sh_lru[s]   = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (4) begin  // Idle cache stays quiet
            @(posedge clk);
            #1;
            if (cpu_resp.valid || mem_req.read || mem_req.write || !cpu_ready) begin
                report_problem("Idle cache showed activity after reset");
            end
        end

        for (int i = 0; i < NUM_REQS; i++) begin
            run_request();
        end
        $display("No errors");
        $finish;
    end

endmodule
